// File: pdp_fabric.f
+incdir+logic
logic/fabric_pkg.sv
logic/dma_master_arbiter.sv
logic/memory_decoder.sv
logic/iopage_decoder.sv
logic/response_collector.sv
logic/pdp_fabric_top.sv
sim/fabric_tb.sv

// File: Bender.yml
package:
  name: pdp_fabric

sources:
  - include_dirs:
      - logic
    files:
      - logic/fabric_pkg.sv
      - logic/dma_master_arbiter.sv
      - logic/memory_decoder.sv
      - logic/iopage_decoder.sv
      - logic/response_collector.sv
      - logic/pdp_fabric_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/fabric_tb.sv

// File: sim/fabric_tests.txt
# name master op adr wdat rdat ack (adr, wdat and rdat in octal)
# master is cpu, rk, my or both; op is rd or wr; ack 1 when an ack is expected
ram_rd_zero   cpu  rd 000000 000000 052525 1
ram_wr_low    cpu  wr 000100 123456 000000 1
ram_rd_1000   cpu  rd 001000 000000 052125 1
ram_rd_2346   cpu  rd 002346 000000 053446 1
ram_rd_top    cpu  rd 137776 000000 005252 1
ram_wr_top    cpu  wr 137776 177777 000000 1
io_tt         cpu  rd 177560 000000 000100 1
io_uart2      cpu  rd 176502 000000 000200 1
io_lp         cpu  rd 177516 000000 000300 1
io_rk         cpu  rd 177404 000000 000400 1
io_dw         cpu  rd 174036 000000 000500 1
io_dx         cpu  rd 177172 000000 000600 1
io_my         cpu  rd 172142 000000 000700 1
io_kgd        cpu  rd 176646 000000 001000 1
io_hole       cpu  rd 177600 000000 000000 0
rom_rd        cpu  rd 150000 000000 004001 1
rom_rd_low    cpu  rd 140002 000000 000002 1
rom_wr        cpu  wr 150000 055555 000000 0
rk_dma_rd     rk   rd 002000 000000 053525 1
rk_dma_io     rk   rd 177560 000000 000100 1
my_dma_rd     my   rd 004000 000000 050525 1
rk_dma_wr     rk   wr 003000 000777 000000 1
prio_rd       both rd 001234 000000 052033 1
prio_io       both rd 172140 000000 000700 1
cpu_after     cpu  rd 000002 000000 052524 1

// File: sim/fabric_tb.sv
//************************************************************
// backplane testbench with sdram, rom and device models,
// test file reader, cpu and dma master sequences
//************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "fabric_cfg.svh"

module fabric_tb
   import fabric_pkg::*;
();

   localparam int          CLK_PERIOD = 100;          // ns
   localparam int          TIMEOUT    = 20;           // cycles per wait
   localparam logic [15:0] SDRAM_PAT  = 16'o052525;   // sdram read pattern
   localparam logic [15:0] DEV_STEP   = 16'o000100;   // device k answers step*(k+1)
   localparam logic [15:0] ROM_LO     = 16'o140000;
   localparam logic [15:0] ROM_HI     = 16'o157777;
   localparam logic [15:0] IO_LO      = 16'o160000;   // i/o page start
   localparam int CPU = 0, RK = 1, MY = 2;

   logic        wb_clk, rst_n_i, sysram_stb, rk_dma_req, my_dma_req;
   wb_req_t     cpu_req, rk_req, my_req, bus_req;
   wb_rsp_t     cpu_rsp, rk_rsp, my_rsp, sdram_rsp;
   wb_rsp_t     dev_rsp [`FABRIC_NUM_DEV];
   dma_gnt_t    dma_gnt;
   dev_sel_t    dev_sel;
   logic        sdram_stb, sdram_ack_q;
   logic [`FABRIC_SDRAM_ADR_W-1:0] sdram_adr;
   logic [`FABRIC_ROM_ADR_W-1:0]   rom_adr;
   logic [15:0] rom_dat;
   logic [7:0]  dev_stb;                              // tt at bit 0

   // current test line
   string       t_name;
   logic [63:0] master_v, op_v;
   logic [15:0] t_adr, t_wdat, t_rdat;
   integer      t_ack;
   integer      seed = 91;

   always #(CLK_PERIOD/2) wb_clk = ~wb_clk;

   pdp_fabric_top DUT (
      .wb_clk(wb_clk), .rst_n_i(rst_n_i),
      .cpu_req_i(cpu_req), .sysram_stb_i(sysram_stb),
      .rk_dma_req_i(rk_dma_req), .rk_req_i(rk_req),
      .my_dma_req_i(my_dma_req), .my_req_i(my_req),
      .cpu_rsp_o(cpu_rsp), .rk_rsp_o(rk_rsp), .my_rsp_o(my_rsp), .dma_gnt_o(dma_gnt),
      .bus_req_o(bus_req), .sdram_stb_o(sdram_stb), .sdram_adr_o(sdram_adr),
      .sdram_rsp_i(sdram_rsp), .rom_adr_o(rom_adr), .rom_dat_i(rom_dat),
      .dev_sel_o(dev_sel), .dev_rsp_i(dev_rsp)
   );

   //*********************************************************
   // slave models
   //*********************************************************
   always @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) sdram_ack_q <= 1'b0;
      else          sdram_ack_q <= sdram_stb & ~sdram_ack_q;   // one cycle late
   end
   assign sdram_rsp = '{ack: sdram_ack_q, dat: sdram_adr[15:0] ^ SDRAM_PAT};
   assign rom_dat   = {4'b0, rom_adr} + 16'd1;                // word address plus one
   assign dev_stb   = {dev_sel.kgd, dev_sel.my, dev_sel.dx, dev_sel.dw,
                       dev_sel.rk, dev_sel.lp, dev_sel.uart2, dev_sel.tt};

   always_comb begin
      for (int k = 0; k < `FABRIC_NUM_DEV; k++) begin
         dev_rsp[k].ack = dev_stb[k];                          // same-cycle ack
         dev_rsp[k].dat = 16'(DEV_STEP * (k + 1));
      end
   end

   //*********************************************************
   // error handling
   //*********************************************************
   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Fail %0s %0s: expected %0o, actual %0o", t_name, what, expected, actual);
         abort_run();
      end
   endtask

   function automatic string master_name(input int who);
      return (who == RK) ? "rk" : (who == MY) ? "my" : "cpu";
   endfunction

   //*********************************************************
   // master sequences
   //*********************************************************
   task automatic drive_req(input int who);               // call at a rising edge
      wb_req_t r;
      r = '{cyc: 1'b1, stb: 1'b1, we: (op_v == "wr"), sel: 2'b11, adr: t_adr, dat: t_wdat};
      if (who != CPU) begin
         r.cyc = 1'b0;                                      // dma cyc is the request level
         r.sel = 2'b00;                                     // arbiter forces both bytes
      end
      case (who)
         RK: begin
            rk_req     <= r;
            rk_dma_req <= 1'b1;
         end
         MY: begin
            my_req     <= r;
            my_dma_req <= 1'b1;
         end
         default: cpu_req <= r;
      endcase
   endtask

   task automatic release_req(input int who);
      case (who)
         RK: begin
            rk_req     <= '0;
            rk_dma_req <= 1'b0;
         end
         MY: begin
            my_req     <= '0;
            my_dma_req <= 1'b0;
         end
         default: cpu_req <= '0;
      endcase
   endtask

   task automatic wait_grant(input int who);
      logic got;
      got = 1'b0;
      for (int n = 0; n < TIMEOUT && !got; n++) begin
         @(negedge wb_clk);
         got = (who == RK) ? dma_gnt.rk : dma_gnt.my;
      end
      if (!got) begin
         $display("%0s: %0s was not granted the bus in time", t_name, master_name(who));
         abort_run();
      end
   endtask

   task automatic wait_ack(input int who, output logic got, output logic [15:0] dat);
      wb_rsp_t rsp;
      got = 1'b0;
      dat = '0;
      for (int n = 0; n < TIMEOUT && !got; n++) begin
         @(negedge wb_clk);
         rsp = (who == RK) ? rk_rsp : (who == MY) ? my_rsp : cpu_rsp;
         if (who != CPU) check_value("cpu ack", 0, cpu_rsp.ack);   // waiting master
         if (who != RK)  check_value("rk ack", 0, rk_rsp.ack);
         if (who != MY)  check_value("my ack", 0, my_rsp.ack);
         if (who != CPU) check_value("dma byte selects", 2'b11, bus_req.sel);
         if (t_adr >= ROM_LO && t_adr <= ROM_HI) check_value("sdram strobe", 0, sdram_stb);
         if (rsp.ack) begin
            got = 1'b1;
            dat = rsp.dat;
            check_value("bus address", t_adr, bus_req.adr);
            check_value("write enable", op_v == "wr", bus_req.we);
            if (op_v == "wr") check_value("write data", t_wdat, bus_req.dat);
            if (t_adr >= IO_LO) check_value("device strobes", 1, $countones(dev_stb));
            if (sdram_stb) check_value("sdram address", t_adr >> 1, sdram_adr);
         end
      end
   endtask

   task automatic check_result(input int who, input logic got, input logic [15:0] dat);
      if (t_ack != 0 && !got) begin
         $display("%0s: no ack for %0s at %0o within %0d cycles",
                  t_name, master_name(who), t_adr, TIMEOUT);
         abort_run();
      end
      check_value("ack", t_ack, got);                       // unexpected ack
      if (got && op_v == "rd") check_value("read data", t_rdat, dat);
   endtask

   task automatic run_test();
      logic        got;
      logic [15:0] dat;
      int          who;
      if (master_v == "cpu") begin
         @(posedge wb_clk) drive_req(CPU);
         wait_ack(CPU, got, dat);
         check_result(CPU, got, dat);
         @(posedge wb_clk) release_req(CPU);
      end else if (master_v == "rk" || master_v == "my") begin
         who = (master_v == "rk") ? RK : MY;
         @(posedge wb_clk) drive_req(who);
         wait_grant(who);
         @(posedge wb_clk) drive_req(CPU);                  // cpu queues behind dma
         wait_ack(who, got, dat);
         check_result(who, got, dat);
         @(posedge wb_clk) release_req(who);
         wait_ack(CPU, got, dat);                           // bus back to the cpu
         check_result(CPU, got, dat);
         check_value("grant after release", 0, dma_gnt);
         @(posedge wb_clk) release_req(CPU);
      end else if (master_v == "both") begin
         @(posedge wb_clk) begin
            drive_req(RK);
            drive_req(MY);
         end
         wait_grant(RK);
         check_value("my grant while rk owns", 0, dma_gnt.my);
         wait_ack(RK, got, dat);
         check_result(RK, got, dat);
         @(posedge wb_clk) release_req(RK);
         wait_grant(MY);                                    // my only after rk drops
         wait_ack(MY, got, dat);
         check_result(MY, got, dat);
         @(posedge wb_clk) release_req(MY);
      end else begin
         $display("%0s: unknown master in the test file", t_name);
         abort_run();
      end
   endtask

   //*********************************************************
   // main sequence
   //*********************************************************
   initial begin
      integer         fd, cnt, ntests, idle;
      logic [1279:0]  line_v;
      logic [191:0]   name_v;
      wb_clk = 1'b0;
      rst_n_i = 1'b0;
      cpu_req = '0;
      rk_req = '0;
      my_req = '0;
      rk_dma_req = 1'b0;
      my_dma_req = 1'b0;
      sysram_stb = 1'b0;
      ntests = 0;
      repeat (2) @(posedge wb_clk);
      rst_n_i <= 1'b1;
      t_name = "reset";
      @(negedge wb_clk);
      check_value("grant", 0, dma_gnt);
      check_value("sdram strobe", 0, sdram_stb);
      check_value("device strobes", 0, dev_sel);
      fd = $fopen("sim/fabric_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open the test file sim/fabric_tests.txt");
         abort_run();
      end
      while (!$feof(fd)) begin
         line_v = '0;
         if ($fgets(line_v, fd) != 0) begin
            cnt = $sscanf(line_v, "%s %s %s %o %o %o %d",
                          name_v, master_v, op_v, t_adr, t_wdat, t_rdat, t_ack);
            if (cnt == 7) begin                             // comment lines fall out here
               t_name = $sformatf("%0s", name_v);
               run_test();
               ntests++;
               idle = $random(seed) & 3;
               repeat (idle) @(posedge wb_clk);
            end
         end
      end
      $fclose(fd);
      if (ntests == 0) begin
         $display("the test file holds no tests");
         abort_run();
      end else begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: logic/pdp_fabric_top.sv
//************************************************************
// shared bus backplane: arbiter, memory and I/O page
// decoders, response collector
//************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "fabric_cfg.svh"

module pdp_fabric_top
   import fabric_pkg::*;
(
   input  wire                              wb_clk,         // bus clock
   input  wire                              rst_n_i,        // async reset, active low

   // masters
   input  wire wb_req_t                     cpu_req_i,      // processor board
   input  wire                              sysram_stb_i,   // cpu service ram
   input  wire                              rk_dma_req_i,
   input  wire wb_req_t                     rk_req_i,
   input  wire                              my_dma_req_i,
   input  wire wb_req_t                     my_req_i,
   output wb_rsp_t                          cpu_rsp_o,
   output wb_rsp_t                          rk_rsp_o,
   output wb_rsp_t                          my_rsp_o,
   output dma_gnt_t                         dma_gnt_o,      // current owner

   // slaves
   output wb_req_t                          bus_req_o,      // we, sel, data, low adr
   output logic                             sdram_stb_o,
   output logic [`FABRIC_SDRAM_ADR_W-1:0]   sdram_adr_o,
   input  wire wb_rsp_t                     sdram_rsp_i,
   output logic [`FABRIC_ROM_ADR_W-1:0]     rom_adr_o,
   input  wire [`FABRIC_DAT_W-1:0]          rom_dat_i,
   output dev_sel_t                         dev_sel_o,      // device strobes
   input  wire wb_rsp_t                     dev_rsp_i [`FABRIC_NUM_DEV]
);

   wire rom_stb;                        // rom window hit
   wire rom_ack;                        // delayed rom ack

   //*********************************************************
   // bus owner
   //*********************************************************
   dma_master_arbiter u_arbiter (
      .wb_clk       (wb_clk),
      .rst_n_i      (rst_n_i),
      .cpu_req_i    (cpu_req_i),
      .rk_dma_req_i (rk_dma_req_i),
      .rk_req_i     (rk_req_i),
      .my_dma_req_i (my_dma_req_i),
      .my_req_i     (my_req_i),
      .gnt_o        (dma_gnt_o),
      .bus_req_o    (bus_req_o)
   );

   //*********************************************************
   // address decode, both on the same request
   //*********************************************************
   memory_decoder u_mem_dec (
      .wb_clk       (wb_clk),
      .rst_n_i      (rst_n_i),
      .bus_req_i    (bus_req_o),
      .sysram_stb_i (sysram_stb_i),
      .sdram_stb_o  (sdram_stb_o),
      .sdram_adr_o  (sdram_adr_o),
      .rom_stb_o    (rom_stb),
      .rom_ack_o    (rom_ack),
      .rom_adr_o    (rom_adr_o)
   );

   iopage_decoder u_io_dec (
      .bus_req_i    (bus_req_o),
      .dev_sel_o    (dev_sel_o)
   );

   // answers back to the owner
   response_collector u_collector (
      .sdram_stb_i  (sdram_stb_o),
      .rom_stb_i    (rom_stb),
      .rom_ack_i    (rom_ack),
      .dev_sel_i    (dev_sel_o),
      .sdram_rsp_i  (sdram_rsp_i),
      .rom_dat_i    (rom_dat_i),
      .dev_rsp_i    (dev_rsp_i),
      .gnt_i        (dma_gnt_o),
      .cpu_rsp_o    (cpu_rsp_o),
      .rk_rsp_o     (rk_rsp_o),
      .my_rsp_o     (my_rsp_o)
   );

endmodule

`default_nettype wire

// File: logic/response_collector.sv
//************************************************************
// ack OR, read data AND-OR mux, ack routing to the bus owner
//************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "fabric_cfg.svh"

module response_collector
   import fabric_pkg::*;
(
   input  wire                        sdram_stb_i,  // ram selected
   input  wire                        rom_stb_i,    // rom selected
   input  wire                        rom_ack_i,    // delayed rom ack
   input  wire dev_sel_t              dev_sel_i,    // device strobes
   input  wire wb_rsp_t               sdram_rsp_i,
   input  wire [`FABRIC_DAT_W-1:0]    rom_dat_i,
   input  wire wb_rsp_t               dev_rsp_i [`FABRIC_NUM_DEV],
   input  wire dma_gnt_t              gnt_i,        // bus owner
   output wb_rsp_t                    cpu_rsp_o,
   output wb_rsp_t                    rk_rsp_o,
   output wb_rsp_t                    my_rsp_o
);

   logic [`FABRIC_NUM_DEV-1:0] dev_stb;            // index matches dev_rsp_i
   logic                       bus_ack;            // global ack
   logic [`FABRIC_DAT_W-1:0]   bus_dat;            // read mux out
   logic                       cpu_owns;           // no dma grant

   // tt sits at index 0
   assign dev_stb = {dev_sel_i.kgd, dev_sel_i.my, dev_sel_i.dx, dev_sel_i.dw,
                     dev_sel_i.rk,  dev_sel_i.lp, dev_sel_i.uart2, dev_sel_i.tt};

   //*********************************************************
   // collect every slave
   //*********************************************************
   always_comb begin
      bus_ack = sdram_rsp_i.ack | rom_ack_i;
      bus_dat = (sdram_stb_i ? sdram_rsp_i.dat : '0)
              | (rom_stb_i   ? rom_dat_i       : '0);
      for (int k = 0; k < `FABRIC_NUM_DEV; k++) begin
         bus_ack = bus_ack | dev_rsp_i[k].ack;
         bus_dat = bus_dat | (dev_stb[k] ? dev_rsp_i[k].dat : '0);
      end
   end

   //*********************************************************
   // ack goes only to the owner, data to all
   //*********************************************************
   assign cpu_owns = ~(gnt_i.rk | gnt_i.my);

   assign cpu_rsp_o = '{ack: bus_ack & cpu_owns, dat: bus_dat};
   assign rk_rsp_o  = '{ack: bus_ack & gnt_i.rk, dat: bus_dat};
   assign my_rsp_o  = '{ack: bus_ack & gnt_i.my, dat: bus_dat};

endmodule

`default_nettype wire

// File: logic/iopage_decoder.sv
//************************************************************
// I/O page strobes for the eight device windows
//************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "fabric_cfg.svh"

module iopage_decoder
   import fabric_pkg::*;
(
   input  wire wb_req_t bus_req_i,      // shared bus
   output dev_sel_t     dev_sel_o       // one strobe per window
);

   logic bus_act;                       // cyc and stb

   //*********************************************************
   // window match on the upper address bits
   //*********************************************************
   function automatic logic win_hit(
      input logic [`FABRIC_ADR_W-1:0] adr,
      input logic [`FABRIC_ADR_W-1:0] base,
      input int unsigned              ign
   );
      return (adr >> ign) == (base >> ign);
   endfunction

   assign bus_act = bus_req_i.cyc & bus_req_i.stb;

   // windows are disjoint, one strobe at most
   always_comb begin
      dev_sel_o.tt    = bus_act &
                        win_hit(bus_req_i.adr, `FABRIC_TT_BASE, `FABRIC_TT_IGN);
      dev_sel_o.uart2 = bus_act &
                        win_hit(bus_req_i.adr, `FABRIC_UART2_BASE, `FABRIC_UART2_IGN);
      dev_sel_o.lp    = bus_act &
                        win_hit(bus_req_i.adr, `FABRIC_LP_BASE, `FABRIC_LP_IGN);
      dev_sel_o.rk    = bus_act &
                        win_hit(bus_req_i.adr, `FABRIC_RK_BASE, `FABRIC_RK_IGN);
      dev_sel_o.dw    = bus_act &
                        win_hit(bus_req_i.adr, `FABRIC_DW_BASE, `FABRIC_DW_IGN);
      dev_sel_o.dx    = bus_act &
                        win_hit(bus_req_i.adr, `FABRIC_DX_BASE, `FABRIC_DX_IGN);
      dev_sel_o.my    = bus_act &
                        win_hit(bus_req_i.adr, `FABRIC_MY_BASE, `FABRIC_MY_IGN);
      dev_sel_o.kgd   = bus_act &
                        win_hit(bus_req_i.adr, `FABRIC_KGD_BASE, `FABRIC_KGD_IGN);
   end

endmodule

`default_nettype wire

// File: logic/memory_decoder.sv
//************************************************************
// RAM and user ROM window decode, SDRAM request,
// delayed ROM read acknowledge
//************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "fabric_cfg.svh"

module memory_decoder
   import fabric_pkg::*;
(
   input  wire                               wb_clk,
   input  wire                               rst_n_i,
   input  wire wb_req_t                      bus_req_i,     // shared bus
   input  wire                               sysram_stb_i,  // cpu service ram
   output logic                              sdram_stb_o,
   output logic [`FABRIC_SDRAM_ADR_W-1:0]    sdram_adr_o,   // word address
   output logic                              rom_stb_o,
   output logic                              rom_ack_o,
   output logic [`FABRIC_ROM_ADR_W-1:0]      rom_adr_o      // rom word address
);

   localparam bit ROM_ON = (`FABRIC_USER_ROM != 0);
   localparam logic [`FABRIC_ADR_W-1:0] RAM_END =
      ROM_ON ? `FABRIC_RAM_END_ROM : `FABRIC_RAM_END_NOROM;

   logic bus_act;                       // cyc and stb
   logic rom_rd;                        // rom read in progress
   logic rom_ack0_q;                    // first delay stage
   logic rom_ack1_q;                    // second stage, drives ack

   assign bus_act = bus_req_i.cyc & bus_req_i.stb;

   // ram below the rom window, service ram on demand
   assign sdram_stb_o = (bus_act & (bus_req_i.adr <= RAM_END)) | sysram_stb_i;
   assign rom_stb_o   = ROM_ON & bus_act &
                        ((bus_req_i.adr >> `FABRIC_ROM_IGN) ==
                         (`FABRIC_ROM_BASE >> `FABRIC_ROM_IGN));

   assign sdram_adr_o = {{(`FABRIC_SDRAM_ADR_W - `FABRIC_ADR_W + 1){1'b0}},
                         bus_req_i.adr[`FABRIC_ADR_W-1:1]};   // drop byte bit
   assign rom_adr_o   = bus_req_i.adr[`FABRIC_ROM_ADR_W:1];

   //*********************************************************
   // rom read ack, two cycles after the strobe
   //*********************************************************
   assign rom_rd = rom_stb_o & ~bus_req_i.we;                 // writes never acked

   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rom_ack0_q <= 1'b0;
         rom_ack1_q <= 1'b0;
      end else begin
         rom_ack0_q <= rom_rd & ~rom_ack1_q;                  // clears after ack
         rom_ack1_q <= rom_rd & rom_ack0_q & ~rom_ack1_q;     // single-cycle ack
      end
   end

   assign rom_ack_o = rom_ack1_q;

endmodule

`default_nettype wire

// File: logic/dma_master_arbiter.sv
//************************************************************
// DMA master arbiter: RK/MY grant flops and bus master switch
//************************************************************
`timescale 1ns/1ps
`default_nettype none
`include "fabric_cfg.svh"

module dma_master_arbiter
   import fabric_pkg::*;
(
   input  wire          wb_clk,         // bus clock
   input  wire          rst_n_i,        // async reset, active low

   input  wire wb_req_t cpu_req_i,      // processor board
   input  wire          rk_dma_req_i,   // rk wants the bus
   input  wire wb_req_t rk_req_i,       // rk dma port
   input  wire          my_dma_req_i,   // my wants the bus
   input  wire wb_req_t my_req_i,       // my dma port

   output dma_gnt_t     gnt_o,          // current owner
   output wb_req_t      bus_req_o       // shared bus
);

   dma_gnt_t gnt_q;                     // grant flops
   logic     bus_idle;                  // no cycle on the bus

   //*********************************************************
   // a DMA port seen from the bus
   //*********************************************************
   function automatic wb_req_t dma_view(
      input wb_req_t req,
      input logic    dma_req
   );
      wb_req_t res;
      res     = req;
      res.cyc = dma_req;                // cycle follows the dma request level
      res.sel = '1;                     // dma moves whole words
      return res;
   endfunction

   assign bus_idle = ~bus_req_o.cyc;

   //*********************************************************
   // grant state
   //*********************************************************
   always_ff @(posedge wb_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gnt_q <= '0;
      end else if (bus_idle) begin      // owner changes between cycles only
         if (rk_dma_req_i) begin        // rk first
            gnt_q.rk <= 1'b1;
            gnt_q.my <= 1'b0;
         end else if (my_dma_req_i) begin
            gnt_q.rk <= 1'b0;
            gnt_q.my <= 1'b1;
         end else begin
            gnt_q <= '0;                // bus back to the cpu
         end
      end
   end

   assign gnt_o = gnt_q;

   //*********************************************************
   // master switch
   //*********************************************************
   always_comb begin
      if (gnt_q.rk) begin
         bus_req_o = dma_view(rk_req_i, rk_dma_req_i);
      end else if (gnt_q.my) begin
         bus_req_o = dma_view(my_req_i, my_dma_req_i);
      end else begin
         bus_req_o = cpu_req_i;         // default owner
      end
   end

endmodule

`default_nettype wire

// File: logic/fabric_pkg.sv
//************************************************************
// request, response, device select and DMA grant types
//************************************************************
`default_nettype none
`include "fabric_cfg.svh"

package fabric_pkg;

   //*********************************************************
   // Wishbone classic request, same for every master
   //*********************************************************
   typedef struct packed {
      logic                      cyc;   // bus cycle
      logic                      stb;   // transfer strobe
      logic                      we;    // 1 = write
      logic [`FABRIC_SEL_W-1:0]  sel;   // byte selects
      logic [`FABRIC_ADR_W-1:0]  adr;   // byte address
      logic [`FABRIC_DAT_W-1:0]  dat;   // write data
   } wb_req_t;

   // slave or bus answer
   typedef struct packed {
      logic                      ack;   // transfer done
      logic [`FABRIC_DAT_W-1:0]  dat;   // read data
   } wb_rsp_t;

   // one strobe per I/O page window
   // dev_rsp index order is tt=0 up to kgd=7
   typedef struct packed {
      logic tt;      // console uart
      logic uart2;   // second uart
      logic lp;      // printer
      logic rk;      // rk11 disk
      logic dw;      // dw hard disk
      logic dx;      // rx01 floppy
      logic my;      // my floppy
      logic kgd;     // graphics
   } dev_sel_t;

   // bus ownership, both clear = cpu
   typedef struct packed {
      logic rk;
      logic my;
   } dma_gnt_t;

endpackage

`default_nettype wire

// File: logic/fabric_cfg.svh
//************************************************************
// bus widths, I/O page device windows, memory map limits
// and user ROM enable of the shared Wishbone backplane
//************************************************************
`ifndef FABRIC_CFG_SVH
`define FABRIC_CFG_SVH

// bus geometry
`define FABRIC_ADR_W        16       // byte address
`define FABRIC_DAT_W        16       // one word
`define FABRIC_SEL_W        2        // byte selects
`define FABRIC_SDRAM_ADR_W  21       // sdram word address
`define FABRIC_ROM_ADR_W    12       // user rom word address
`define FABRIC_NUM_DEV      8        // i/o page devices

// main memory map
`define FABRIC_USER_ROM       1           // user rom at 140000
`define FABRIC_RAM_END_ROM    16'o137777  // ram top with rom
`define FABRIC_RAM_END_NOROM  16'o157777  // ram top without rom
`define FABRIC_ROM_BASE       16'o140000  // rom window start
`define FABRIC_ROM_IGN        13          // 8 KB rom window

// device window bases, octal
`define FABRIC_TT_BASE     16'o177560
`define FABRIC_UART2_BASE  16'o176500
`define FABRIC_LP_BASE     16'o177514
`define FABRIC_RK_BASE     16'o177400
`define FABRIC_DW_BASE     16'o174000
`define FABRIC_DX_BASE     16'o177170
`define FABRIC_MY_BASE     16'o172140
`define FABRIC_KGD_BASE    16'o176640

// window sizes as ignored low address bits
`define FABRIC_TT_IGN      3         // 8 bytes
`define FABRIC_UART2_IGN   3
`define FABRIC_LP_IGN      2         // 4 bytes
`define FABRIC_RK_IGN      4         // 16 bytes
`define FABRIC_DW_IGN      5         // 32 bytes
`define FABRIC_DX_IGN      2
`define FABRIC_MY_IGN      2
`define FABRIC_KGD_IGN     3

`endif
